/* bench/core_properties.sv */
// Bound into core; checks fetch redirect, stall length, store squash and PC after reset
`timescale 1ns/100ps
`default_nettype none

module core_properties (
	input logic          clk,
	input logic          rst,
	input logic          stall,
	input logic          flush,
	input core_pkg::pc_t pc,
	input core_pkg::pc_t redirect_pc,
	input logic          dm_we
);
	import core_pkg::*;

	// PC takes the branch or jump target even if a stall was pending
	assert property (@(posedge clk) disable iff (rst) flush |=> pc == $past(redirect_pc))
		else $error("PC did not follow a taken branch or jump");

	// Load-use costs exactly one bubble
	assert property (@(posedge clk) disable iff (rst) stall |=> !stall)
		else $error("stall longer than one cycle");

	// The two squashed instructions would reach memory two and three cycles later
	assert property (@(posedge clk) disable iff (rst)
		($past(flush, 2) || $past(flush, 3)) |-> !dm_we)
		else $error("memory write from an instruction squashed by a flush");

	// First cycle out of reset fetches from zero
	assert property (@(posedge clk) $fell(rst) |-> pc == '0)
		else $error("PC not zero after reset");

endmodule

bind core core_properties u_props (
	.clk(clk),
	.rst(rst),
	.stall(stall),
	.flush(flush),
	.pc(u_fetch.pc),
	.redirect_pc(ex_redirect_pc),
	.dm_we(mem_dm_we)
);

`default_nettype wire

/* bench/core_stim.txt */
# I byte_addr inst | D word_addr byte_mask data | R run_cycles | E word_addr expected
# Arithmetic and logic with forwarding, results stored from word 0x40
I 000 00500093
I 004 ffd00113
I 008 002081b3
I 00c 40208233
I 010 0020f2b3
I 014 0041c333
I 018 001123b3
I 01c 00113433
I 020 40115493
I 024 12345537
I 028 10302023
I 02c 10402223
I 030 10502423
I 034 10602623
I 038 10702823
I 03c 10802a23
I 040 10902c23
I 044 10a02e23
# Load-use pair, then branches and jumps
I 048 20002583
I 04c 00158613
I 050 12c02023
I 054 00108463
I 058 12102223
I 05c 00109463
I 060 12102423
I 064 00114463
I 068 12102623
I 06c 00115463
I 070 12202823
I 074 00c0076f
I 078 12102a23
I 07c 00000013
I 080 12e02c23
I 084 014707e7
I 088 12102e23
I 08c 14f02023
I 090 0000006f
# Load source, wrong-path sentinels and a partial byte write
D 080 f 11223344
D 049 f deadbeef
D 04b f deadbeef
D 04d f deadbeef
D 04f f deadbeef
D 051 f aabbccdd
D 051 5 11223344
R 80
E 040 00000002
E 041 00000008
E 042 00000005
E 043 0000000a
E 044 00000001
E 045 00000000
E 046 fffffffe
E 047 12345000
E 048 11223345
E 049 deadbeef
E 04a 00000005
E 04b deadbeef
E 04c fffffffd
E 04d deadbeef
E 04e 00000078
E 04f deadbeef
E 050 00000088
E 051 aa22cc44

/* bench/tb_core.sv */
// Reads bench/core_stim.txt from the project root; programs are loaded only while rst is high
`timescale 1ns/100ps
`default_nettype none

module tb_core;
	import core_pkg::*;

	logic      clk;
	logic      rst;
	logic      imem_we;
	pc_t       imem_addr;
	inst_t     imem_data;
	logic [3:0] con_write;
	dm_addr_t  con_addr;
	xlen_t     con_in;
	xlen_t     con_out;

	int value_errs;
	int other_errs;
	int cycles;
	int limit;                     // Zero until the stim file is parsed

	// Parsed stim records
	pc_t        i_addr [$];
	inst_t      i_data [$];
	dm_addr_t   d_addr [$];
	logic [3:0] d_mask [$];
	xlen_t      d_data [$];
	dm_addr_t   e_addr [$];
	xlen_t      e_data [$];
	int         run_len;

	core DUT (
		.clk(clk), .rst(rst), .imem_we(imem_we), .imem_addr(imem_addr),
		.imem_data(imem_data), .con_write(con_write), .con_addr(con_addr),
		.con_in(con_in), .con_out(con_out)
	);

	always #50 clk = ~clk;         // 100 ns period

	// Run limit watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles > limit) begin
			$display("Timeout: run did not finish within %0d cycles", limit);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	task automatic check_word(input dm_addr_t addr, input xlen_t expected, input xlen_t actual);
		if (actual !== expected) begin
			$display("Fail con_out at word %h: expected %h, got %h", addr, expected, actual);
			value_errs++;
		end
	endtask

	task automatic report_bad_line(input logic [63:0] tag);
		$display("Stim file has a line that cannot be parsed, tag '%0s'", tag);
		other_errs++;
	endtask

	task automatic parse_stim;
		int fd;
		int n;
		int done;
		logic [63:0] tag;
		logic [8*256-1:0] rest;
		logic [31:0] a;
		logic [31:0] m;
		logic [31:0] v;
		fd = $fopen("bench/core_stim.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stim file bench/core_stim.txt");
			other_errs++;
		end else begin
			done = 0;
			while (!done && !$feof(fd)) begin
				n = $fscanf(fd, "%s", tag);
				if (n != 1)
					done = 1;
				else if (tag == "#")
					n = $fgets(rest, fd);  // Comment line
				else if (tag == "I" && $fscanf(fd, "%h %h", a, v) == 2) begin
					i_addr.push_back(pc_t'(a));
					i_data.push_back(v);
				end else if (tag == "D" && $fscanf(fd, "%h %h %h", a, m, v) == 3) begin
					d_addr.push_back(dm_addr_t'(a));
					d_mask.push_back(m[3:0]);
					d_data.push_back(v);
				end else if (tag == "R" && $fscanf(fd, "%d", v) == 1)
					run_len = v;
				else if (tag == "E" && $fscanf(fd, "%h %h", a, v) == 2) begin
					e_addr.push_back(dm_addr_t'(a));
					e_data.push_back(v);
				end else begin
					report_bad_line(tag);
					done = 1;
				end
			end
			$fclose(fd);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		con_write = '0;
		con_addr = '0;
		con_in = '0;
		value_errs = 0;
		other_errs = 0;
		cycles = 0;
		limit = 0;
		run_len = 0;
		parse_stim();
		limit = i_addr.size() + d_addr.size() + e_addr.size() + run_len + 50;
		repeat (2) @(posedge clk);   // Fetch FSM settles in loading
		foreach (i_addr[k]) begin
			@(posedge clk);
			imem_we   <= 1'b1;
			imem_addr <= i_addr[k];
			imem_data <= i_data[k];
		end
		foreach (d_addr[k]) begin
			@(posedge clk);
			imem_we   <= 1'b0;
			con_write <= d_mask[k];
			con_addr  <= d_addr[k];
			con_in    <= d_data[k];
		end
		@(posedge clk);
		imem_we   <= 1'b0;
		con_write <= '0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		repeat (run_len) @(posedge clk);
		foreach (e_addr[k]) begin
			@(posedge clk);
			con_addr <= e_addr[k];
			@(negedge clk);            // Async read has settled
			check_word(e_addr[k], e_data[k], con_out);
		end
		if (e_addr.size() == 0) begin
			$display("Stim file holds no expected words");
			other_errs++;
		end
		$display("Errors: %0d wrong values, %0d other", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/alu.sv */
// Branch compare covers BEQ, BNE, BLT and BGE only; other branch funct3 codes are never taken
`timescale 1ns/100ps
`default_nettype none

module alu (
	input  core_pkg::xlen_t   a,
	input  core_pkg::xlen_t   b,
	input  core_pkg::alu_op_t op,
	input  logic [2:0]        funct3,
	input  logic              is_branch,
	input  logic              is_jump,
	output core_pkg::xlen_t   result,
	output logic              taken
);
	import core_pkg::*;

	logic lt_s;                 // Signed less than
	logic cond;

	assign lt_s = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			ALU_SUB:  result = a - b;
			ALU_AND:  result = a & b;
			ALU_OR:   result = a | b;
			ALU_XOR:  result = a ^ b;
			ALU_SLT:  result = xlen_t'(lt_s);
			ALU_SLTU: result = xlen_t'(a < b);
			ALU_SLL:  result = a << b[4:0];
			ALU_SRL:  result = a >> b[4:0];
			ALU_SRA:  result = $signed(a) >>> b[4:0];
			default:  result = a + b;      // ADD, loads, stores, LUI
		endcase
	end

	always_comb begin
		case (funct3)
			3'b000:  cond = (a == b);       // BEQ
			3'b001:  cond = (a != b);       // BNE
			3'b100:  cond = lt_s;           // BLT
			3'b101:  cond = !lt_s;          // BGE
			default: cond = 1'b0;
		endcase
	end

	assign taken = is_jump || (is_branch && cond);

endmodule

`default_nettype wire

/* hw/core.sv */
// Five-stage RV32I subset core; branches resolve in execute, no interrupts, no byte or half access
`timescale 1ns/100ps
`default_nettype none

module core (
	input  logic               clk,
	input  logic               rst,
	input  logic               imem_we,
	input  core_pkg::pc_t      imem_addr,
	input  core_pkg::inst_t    imem_data,
	input  logic [3:0]         con_write,
	input  core_pkg::dm_addr_t con_addr,
	input  core_pkg::xlen_t    con_in,
	output core_pkg::xlen_t    con_out
);
	import core_pkg::*;

	// Picks the value a stage would write back
	function automatic xlen_t wb_pick(wb_sel_t sel, pc_t pc4, xlen_t alu_res, xlen_t load);
		case (sel)
			WB_PC4:  return xlen_t'(pc4);   // Zero extended link address
			WB_LOAD: return load;
			default: return alu_res;
		endcase
	endfunction

	function automatic xlen_t fwd_pick(fwd_sel_t sel, xlen_t rf, xlen_t from_mem, xlen_t from_wb);
		case (sel)
			FWD_MEM: return from_mem;
			FWD_WB:  return from_wb;
			default: return rf;
		endcase
	endfunction

	// Decode stage
	inst_t     id_inst;
	pc_t       id_pc;
	reg_addr_t id_rs1, id_rs2, id_rd;
	xlen_t     id_imm, id_rdata1, id_rdata2;
	alu_op_t   id_alu_op;
	wb_sel_t   id_wb_sel;
	logic      id_use_imm, id_use_pc, id_reg_write, id_mem_read, id_mem_write;
	logic      id_is_branch, id_is_jump, id_is_jalr;

	// Execute stage
	pc_t       ex_pc, ex_pc4, ex_target, ex_redirect_pc;
	reg_addr_t ex_rs1, ex_rs2, ex_rd;
	xlen_t     ex_imm, ex_rdata1, ex_rdata2, ex_a, ex_fwd_b, ex_b, ex_result;
	alu_op_t   ex_alu_op;
	wb_sel_t   ex_wb_sel;
	logic [2:0] ex_funct3;
	logic      ex_use_imm, ex_use_pc, ex_is_jalr;
	logic      ex_reg_write, ex_mem_read, ex_mem_write, ex_is_branch, ex_is_jump;
	logic      ex_taken;

	// Memory and writeback stages
	pc_t       mem_pc4, wb_pc4;
	reg_addr_t mem_rd, wb_rd;
	xlen_t     mem_alu, mem_store, mem_rdata, mem_fwd_data;
	xlen_t     wb_alu, wb_load, wb_data;
	wb_sel_t   mem_wb_sel, wb_sel;
	logic      mem_reg_write, mem_dm_we, wb_reg_write;

	fwd_sel_t  forward_a, forward_b;
	logic      stall, flush;

	fetch_unit u_fetch (
		.clk(clk), .rst(rst), .stall(stall), .flush(flush),
		.redirect(ex_taken), .redirect_pc(ex_redirect_pc),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
		.id_inst(id_inst), .id_pc(id_pc)
	);

	decoder u_dec (
		.inst(id_inst), .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd), .imm(id_imm),
		.alu_op(id_alu_op), .use_imm(id_use_imm), .use_pc(id_use_pc),
		.reg_write(id_reg_write), .mem_read(id_mem_read), .mem_write(id_mem_write),
		.is_branch(id_is_branch), .is_jump(id_is_jump), .is_jalr(id_is_jalr),
		.wb_sel(id_wb_sel)
	);

	regfile u_rf (
		.clk(clk), .rst(rst), .rs1(id_rs1), .rs2(id_rs2),
		.rdata1(id_rdata1), .rdata2(id_rdata2),
		.we(wb_reg_write), .waddr(wb_rd), .wdata(wb_data)
	);

	hazard_unit u_haz (
		.id_rs1(id_rs1), .id_rs2(id_rs2), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2),
		.ex_rd(ex_rd), .mem_rd(mem_rd), .wb_rd(wb_rd), .ex_mem_read(ex_mem_read),
		.mem_reg_write(mem_reg_write), .wb_reg_write(wb_reg_write), .taken(ex_taken),
		.forward_a(forward_a), .forward_b(forward_b), .stall(stall), .flush(flush)
	);

	// ID/EX control, bubbled on stall or flush
	always_ff @(posedge clk) begin
		if (rst || flush || stall) begin
			{ex_reg_write, ex_mem_read, ex_mem_write, ex_is_branch, ex_is_jump} <= '0;
		end else begin
			ex_reg_write <= id_reg_write;
			ex_mem_read  <= id_mem_read;
			ex_mem_write <= id_mem_write;
			ex_is_branch <= id_is_branch;
			ex_is_jump   <= id_is_jump;
		end
	end

	// ID/EX payload
	always_ff @(posedge clk) begin
		ex_pc      <= id_pc;
		ex_rs1     <= id_rs1;
		ex_rs2     <= id_rs2;
		ex_rd      <= id_rd;
		ex_imm     <= id_imm;
		ex_rdata1  <= id_rdata1;
		ex_rdata2  <= id_rdata2;
		ex_alu_op  <= id_alu_op;
		ex_wb_sel  <= id_wb_sel;
		ex_funct3  <= id_inst[14:12];
		ex_use_imm <= id_use_imm;
		ex_use_pc  <= id_use_pc;
		ex_is_jalr <= id_is_jalr;
	end

	// Loads in memory forward the async read data
	assign mem_fwd_data = wb_pick(mem_wb_sel, mem_pc4, mem_alu, mem_rdata);
	assign ex_a     = fwd_pick(forward_a, ex_rdata1, mem_fwd_data, wb_data);
	assign ex_fwd_b = fwd_pick(forward_b, ex_rdata2, mem_fwd_data, wb_data); // Also store data
	assign ex_b     = ex_use_imm ? ex_imm : ex_fwd_b;

	alu u_alu (
		.a(ex_a), .b(ex_b), .op(ex_alu_op), .funct3(ex_funct3),
		.is_branch(ex_is_branch), .is_jump(ex_is_jump),
		.result(ex_result), .taken(ex_taken)
	);

	// PC relative for branches and JAL, register based for JALR
	assign ex_target      = (ex_use_pc ? ex_pc : ex_a[PC_W-1:0]) + ex_imm[PC_W-1:0];
	assign ex_redirect_pc = {ex_target[PC_W-1:1], ex_target[0] & ~ex_is_jalr};
	assign ex_pc4         = ex_pc + pc_t'(4);

	// EX/MEM
	always_ff @(posedge clk) begin
		if (rst) begin
			mem_reg_write <= 1'b0;
			mem_dm_we     <= 1'b0;
		end else begin
			mem_reg_write <= ex_reg_write;
			mem_dm_we     <= ex_mem_write;
		end
		mem_alu    <= ex_result;
		mem_store  <= ex_fwd_b;
		mem_rd     <= ex_rd;
		mem_pc4    <= ex_pc4;
		mem_wb_sel <= ex_wb_sel;
	end

	datamem u_dmem (
		.clk(clk), .we(mem_dm_we), .addr(mem_alu[DM_AW+1:2]), .wdata(mem_store),
		.rdata(mem_rdata), .con_write(con_write), .con_addr(con_addr),
		.con_in(con_in), .con_out(con_out)
	);

	// MEM/WB
	always_ff @(posedge clk) begin
		if (rst)
			wb_reg_write <= 1'b0;
		else
			wb_reg_write <= mem_reg_write;
		wb_alu  <= mem_alu;
		wb_load <= mem_rdata;
		wb_rd   <= mem_rd;
		wb_pc4  <= mem_pc4;
		wb_sel  <= mem_wb_sel;
	end

	assign wb_data = wb_pick(wb_sel, wb_pc4, wb_alu, wb_load);

endmodule

`default_nettype wire

/* hw/core_pkg.sv */
// RV32I subset only; 4 KiB instruction space, 8 KiB word-only data space, no CSRs
`default_nettype none

package core_pkg;

	localparam int XLEN     = 32;             // Data path width
	localparam int PC_W     = 12;             // Byte address into instruction memory
	localparam int IM_DEPTH = 2 ** (PC_W - 2); // 1024 instruction words
	localparam int DM_AW    = 11;             // Word address into data memory
	localparam int DM_DEPTH = 2 ** DM_AW;     // 2048 data words
	localparam int REG_AW   = 5;

	typedef logic [XLEN-1:0]   xlen_t;
	typedef logic [PC_W-1:0]   pc_t;
	typedef logic [REG_AW-1:0] reg_addr_t;
	typedef logic [DM_AW-1:0]  dm_addr_t;
	typedef logic [31:0]       inst_t;

	// Major opcodes of the supported subset
	localparam logic [6:0] OP_R      = 7'b0110011;
	localparam logic [6:0] OP_I      = 7'b0010011;
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;

	localparam inst_t NOP_INST = 32'h0000_0013; // addi x0, x0, 0

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
	} alu_op_t;

	// Source of the register write data
	typedef enum logic [1:0] {WB_PC4, WB_ALU, WB_LOAD} wb_sel_t;

	// Execute operand source
	typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_t;

	typedef enum logic {FS_LOADING, FS_RUNNING} fetch_state_t;

endpackage

`default_nettype wire

/* hw/datamem.sv */
// Word-only core port; controller port writes bytes by mask and wins on a same-word collision
`timescale 1ns/100ps
`default_nettype none

module datamem (
	input  logic               clk,
	input  logic               we,
	input  core_pkg::dm_addr_t addr,
	input  core_pkg::xlen_t    wdata,
	output core_pkg::xlen_t    rdata,
	input  logic [3:0]         con_write,
	input  core_pkg::dm_addr_t con_addr,
	input  core_pkg::xlen_t    con_in,
	output core_pkg::xlen_t    con_out
);
	import core_pkg::*;

	xlen_t mem [DM_DEPTH];

	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;                   // Full word store from the core
		for (int i = 0; i < 4; i++) begin
			if (con_write[i])
				mem[con_addr][8*i +: 8] <= con_in[8*i +: 8]; // Later assignment wins
		end
	end

	assign rdata   = mem[addr];    // Async read for the memory stage
	assign con_out = mem[con_addr];

endmodule

`default_nettype wire

/* hw/decoder.sv */
// Decodes the RV32I subset only; LW/SW word access, unsupported encodings become a NOP
`timescale 1ns/100ps
`default_nettype none

module decoder (
	input  core_pkg::inst_t     inst,
	output core_pkg::reg_addr_t rs1,
	output core_pkg::reg_addr_t rs2,
	output core_pkg::reg_addr_t rd,
	output core_pkg::xlen_t     imm,
	output core_pkg::alu_op_t   alu_op,
	output logic                use_imm,
	output logic                use_pc,
	output logic                reg_write,
	output logic                mem_read,
	output logic                mem_write,
	output logic                is_branch,
	output logic                is_jump,
	output logic                is_jalr,
	output core_pkg::wb_sel_t   wb_sel
);
	import core_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	alu_op_t    arith_op;            // funct3 mapping shared by R and I forms
	logic       r_ok;
	xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// Only funct7 0x00, or 0x20 on SUB/SRA; M extension falls out here
	assign r_ok = (funct7 == 7'h00) || (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));

	always_comb begin
		case (funct3)
			3'b000:  arith_op = (opcode == OP_R && funct7[5]) ? ALU_SUB : ALU_ADD; // No SUBI
			3'b001:  arith_op = ALU_SLL;
			3'b010:  arith_op = ALU_SLT;
			3'b011:  arith_op = ALU_SLTU;
			3'b100:  arith_op = ALU_XOR;
			3'b101:  arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
			3'b110:  arith_op = ALU_OR;
			default: arith_op = ALU_AND;
		endcase
	end

	always_comb begin
		// NOP defaults; unused sources stay x0 so they never raise a hazard
		rs1 = '0;
		rs2 = '0;
		rd = '0;
		imm = '0;
		alu_op = ALU_ADD;
		use_imm = 1'b0;
		use_pc = 1'b0;
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		is_branch = 1'b0;
		is_jump = 1'b0;
		is_jalr = 1'b0;
		wb_sel = WB_ALU;
		case (opcode)
			OP_R: if (r_ok) begin
				{rs1, rs2, rd} = {inst[19:15], inst[24:20], inst[11:7]};
				alu_op = arith_op;
				reg_write = 1'b1;
			end
			OP_I: begin
				{rs1, rd} = {inst[19:15], inst[11:7]};
				imm = imm_i;
				alu_op = arith_op;
				use_imm = 1'b1;
				reg_write = 1'b1;
			end
			OP_LUI: begin                        // x0 + imm through the adder
				rd = inst[11:7];
				imm = imm_u;
				use_imm = 1'b1;
				reg_write = 1'b1;
			end
			OP_LOAD: if (funct3 == 3'b010) begin // LW only
				{rs1, rd} = {inst[19:15], inst[11:7]};
				imm = imm_i;
				use_imm = 1'b1;
				reg_write = 1'b1;
				mem_read = 1'b1;
				wb_sel = WB_LOAD;
			end
			OP_STORE: if (funct3 == 3'b010) begin // SW only
				{rs1, rs2} = {inst[19:15], inst[24:20]};
				imm = imm_s;
				use_imm = 1'b1;
				mem_write = 1'b1;
			end
			OP_BRANCH: begin
				{rs1, rs2} = {inst[19:15], inst[24:20]};
				imm = imm_b;
				alu_op = ALU_SUB;
				use_pc = 1'b1;                   // Target is PC relative
				is_branch = 1'b1;
			end
			OP_JAL: begin
				rd = inst[11:7];
				imm = imm_j;
				use_pc = 1'b1;
				reg_write = 1'b1;
				is_jump = 1'b1;
				wb_sel = WB_PC4;                 // Link value
			end
			OP_JALR: begin
				{rs1, rd} = {inst[19:15], inst[11:7]};
				imm = imm_i;
				reg_write = 1'b1;
				is_jump = 1'b1;
				is_jalr = 1'b1;
				wb_sel = WB_PC4;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* hw/fetch_unit.sv */
// Instruction memory is writable only while rst holds the fetch FSM in loading; fetch is word only
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
	input  logic            clk,
	input  logic            rst,
	input  logic            stall,
	input  logic            flush,
	input  logic            redirect,
	input  core_pkg::pc_t   redirect_pc,
	input  logic            imem_we,
	input  core_pkg::pc_t   imem_addr,
	input  core_pkg::inst_t imem_data,
	output core_pkg::inst_t id_inst,
	output core_pkg::pc_t   id_pc
);
	import core_pkg::*;

	fetch_state_t state;
	pc_t          pc;
	pc_t          pc_next;
	inst_t        if_inst;
	logic         run;                 // Clock enable for PC and IF/ID
	inst_t        imem [IM_DEPTH];

	// Leaves loading on the first edge with rst low
	always_ff @(posedge clk) begin
		if (rst)
			state <= FS_LOADING;
		else
			state <= FS_RUNNING;
	end

	assign run = (state == FS_RUNNING);

	always_ff @(posedge clk) begin
		if (imem_we && state == FS_LOADING)
			imem[imem_addr[PC_W-1:2]] <= imem_data; // Byte address, word index
	end

	assign if_inst = imem[pc[PC_W-1:2]];        // Async read
	assign pc_next = redirect ? redirect_pc : pc + pc_t'(4);

	always_ff @(posedge clk) begin
		if (rst)
			pc <= '0;
		else if (run && (redirect || !stall)) // Redirect beats a stall
			pc <= pc_next;
	end

	// IF/ID register
	always_ff @(posedge clk) begin
		if (rst) begin
			id_inst <= NOP_INST;
			id_pc   <= '0;
		end else if (run) begin
			if (flush)
				id_inst <= NOP_INST;      // Squash wrong-path fetch
			else if (!stall) begin
				id_inst <= if_inst;
				id_pc   <= pc;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/hazard_unit.sv */
// Forwards into execute from memory and writeback; a load-use pair costs one bubble
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
	input  core_pkg::reg_addr_t id_rs1,
	input  core_pkg::reg_addr_t id_rs2,
	input  core_pkg::reg_addr_t ex_rs1,
	input  core_pkg::reg_addr_t ex_rs2,
	input  core_pkg::reg_addr_t ex_rd,
	input  core_pkg::reg_addr_t mem_rd,
	input  core_pkg::reg_addr_t wb_rd,
	input  logic                ex_mem_read,
	input  logic                mem_reg_write,
	input  logic                wb_reg_write,
	input  logic                taken,
	output core_pkg::fwd_sel_t  forward_a,
	output core_pkg::fwd_sel_t  forward_b,
	output logic                stall,
	output logic                flush
);
	import core_pkg::*;

	logic mem_hit_a, mem_hit_b;
	logic wb_hit_a, wb_hit_b;
	logic load_use;

	// x0 writers never match
	assign mem_hit_a = mem_reg_write && mem_rd != '0 && mem_rd == ex_rs1;
	assign mem_hit_b = mem_reg_write && mem_rd != '0 && mem_rd == ex_rs2;
	assign wb_hit_a  = wb_reg_write && wb_rd != '0 && wb_rd == ex_rs1;
	assign wb_hit_b  = wb_reg_write && wb_rd != '0 && wb_rd == ex_rs2;

	// Youngest producer wins
	assign forward_a = mem_hit_a ? FWD_MEM : wb_hit_a ? FWD_WB : FWD_NONE;
	assign forward_b = mem_hit_b ? FWD_MEM : wb_hit_b ? FWD_WB : FWD_NONE;

	// Load in execute feeding the instruction in decode
	assign load_use = ex_mem_read && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);

	assign stall = load_use && !taken;   // Wrong-path consumer is flushed instead
	assign flush = taken;                // Kills IF/ID and ID/EX contents

endmodule

`default_nettype wire

/* hw/regfile.sv */
// Two async read ports, one write port; x0 reads zero and a same-cycle write is bypassed
`timescale 1ns/100ps
`default_nettype none

module regfile (
	input  logic                clk,
	input  logic                rst,
	input  core_pkg::reg_addr_t rs1,
	input  core_pkg::reg_addr_t rs2,
	output core_pkg::xlen_t     rdata1,
	output core_pkg::xlen_t     rdata2,
	input  logic                we,
	input  core_pkg::reg_addr_t waddr,
	input  core_pkg::xlen_t     wdata
);
	import core_pkg::*;

	xlen_t regs [2**REG_AW];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**REG_AW; i++)
				regs[i] <= '0;
		end else if (we && waddr != '0)  // x0 stays zero
			regs[waddr] <= wdata;
	end

	// Writeback to decode bypass
	assign rdata1 = (rs1 == '0) ? '0 : (we && waddr == rs1) ? wdata : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : (we && waddr == rs2) ? wdata : regs[rs2];

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it into sim.log and checks the log
rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_core -o tb_core_sim \
	&& ./obj_dir/tb_core_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "PASS: all tests" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* sources.f */
hw/core_pkg.sv
hw/fetch_unit.sv
hw/decoder.sv
hw/regfile.sv
hw/alu.sv
hw/hazard_unit.sv
hw/datamem.sv
hw/core.sv
bench/core_properties.sv
bench/tb_core.sv
